// File: Makefile
# Verilator build and run for the adc retimer testbench
VERILATOR ?= verilator
TOP       ?= tb_adc_retimer
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || (echo "simulation FAILED, no result line"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/retimer_consts.svh
/* sizing macros for the adc retimer: slice count, sample widths, fifo depth, tag width,
   plus the command opcodes */
`ifndef RETIMER_CONSTS_SVH
`define RETIMER_CONSTS_SVH

// interleave and replica slices
`define RT_NTI         16
`define RT_NREP        2

// magnitude bits per slice, two's complement adds one
`define RT_NADC        8
`define RT_SW          (`RT_NADC + 1)

// output side
`define RT_FIFO_DEPTH  4
`define RT_TAG_W       16

// command word opcodes
`define RT_OP_CAP_ON   4'h1
`define RT_OP_CAP_OFF  4'h2

`endif

// File: list.f
+incdir+include
source/retimer_pkg.sv
source/retimer_ctrl.sv
source/lane_retimer.sv
source/sample_formatter.sv
source/frame_fifo.sv
source/adc_retimer_top.sv
test/retimer_checker.sv
test/tb_adc_retimer.sv

// File: source/adc_retimer_top.sv
/* top level of the interleaved adc back end: control, lane retimer,
   formatter and output fifo */
`timescale 1ns/10ps
`include "retimer_consts.svh"

module adc_retimer_top (
    input  logic                    clk_retimer,
    input  logic                    arst_n,
    // slices
    input  logic [`RT_NADC-1:0]     in_data     [`RT_NTI],
    input  logic [`RT_NTI-1:0]      in_sign,
    input  logic [`RT_NADC-1:0]     in_data_rep [`RT_NREP],
    input  logic [`RT_NREP-1:0]     in_sign_rep,
    // config port
    input  logic                    cfg_valid,
    output logic                    cfg_ready,
    input  logic                    cfg_is_mask,
    input  retimer_pkg::cfg_word_u  cfg_word,
    // frame port
    output logic                    out_valid,
    input  logic                    out_ready,
    output retimer_pkg::frame_t     out_frame,
    output retimer_pkg::rep_frame_t out_rep,
    output logic [`RT_TAG_W-1:0]    out_tag,
    // status
    output logic [15:0]             drop_count,
    output logic                    capture_on
);

    // control -> datapath
    logic [`RT_NTI-1:0]   mux_ctrl_1;
    logic [`RT_NTI-1:0]   mux_ctrl_2;
    logic                 frame_valid;
    logic [`RT_TAG_W-1:0] frame_tag;
    logic                 clear_drops;

    // retimer -> formatter
    logic [`RT_NADC-1:0]  lane_data [`RT_NTI];
    logic [`RT_NTI-1:0]   lane_sign;
    logic [`RT_NADC-1:0]  rep_data  [`RT_NREP];
    logic [`RT_NREP-1:0]  rep_sign;

    // formatter -> fifo
    logic                    fmt_valid;
    retimer_pkg::frame_t     fmt_frame;
    retimer_pkg::rep_frame_t fmt_rep;
    logic [`RT_TAG_W-1:0]    fmt_tag;

    retimer_ctrl u_ctrl (
        .clk_retimer, .arst_n,
        .cfg_valid, .cfg_ready, .cfg_is_mask, .cfg_word,
        .mux_ctrl_1, .mux_ctrl_2,
        .capture_on, .frame_valid, .frame_tag, .clear_drops
    );

    lane_retimer u_lanes (
        .clk_retimer, .arst_n,
        .in_data, .in_sign, .in_data_rep, .in_sign_rep,
        .mux_ctrl_1, .mux_ctrl_2,
        .lane_data, .lane_sign, .rep_data, .rep_sign
    );

    sample_formatter u_fmt (
        .clk_retimer, .arst_n,
        .lane_data, .lane_sign, .rep_data, .rep_sign,
        .frame_valid, .frame_tag,
        .fmt_valid, .fmt_frame, .fmt_rep, .fmt_tag
    );

    frame_fifo u_fifo (
        .clk_retimer, .arst_n,
        .push_valid (fmt_valid),
        .push_frame (fmt_frame),
        .push_rep   (fmt_rep),
        .push_tag   (fmt_tag),
        .clear_drops,
        .out_valid, .out_ready, .out_frame, .out_rep, .out_tag,
        .drop_count
    );

endmodule

// File: source/frame_fifo.sv
/* frame fifo with valid/ready read side; pushes into a full fifo
   are dropped and counted */
`timescale 1ns/10ps
`include "retimer_consts.svh"

module frame_fifo (
    input  logic                    clk_retimer,
    input  logic                    arst_n,
    // write side, cannot stall
    input  logic                    push_valid,
    input  retimer_pkg::frame_t     push_frame,
    input  retimer_pkg::rep_frame_t push_rep,
    input  logic [`RT_TAG_W-1:0]    push_tag,
    input  logic                    clear_drops,
    // read side
    output logic                    out_valid,
    input  logic                    out_ready,
    output retimer_pkg::frame_t     out_frame,
    output retimer_pkg::rep_frame_t out_rep,
    output logic [`RT_TAG_W-1:0]    out_tag,
    output logic [15:0]             drop_count
);

    localparam int DEPTH = `RT_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    retimer_pkg::frame_t     mem_frame [DEPTH];
    retimer_pkg::rep_frame_t mem_rep   [DEPTH];
    logic [`RT_TAG_W-1:0]    mem_tag   [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;                         // 0 .. DEPTH
    logic             full;
    logic             push;
    logic             pop;

    // wrap for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full      = (count == (PTR_W + 1)'(DEPTH));
    assign push      = push_valid & ~full;           // full at push -> drop
    assign out_valid = (count != '0);
    assign pop       = out_valid & out_ready;

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_retimer) begin
        if (push) begin
            mem_frame[wr_ptr] <= push_frame;
            mem_rep[wr_ptr]   <= push_rep;
            mem_tag[wr_ptr]   <= push_tag;
        end
    end

    // head entry, stable until popped
    assign out_frame = mem_frame[rd_ptr];
    assign out_rep   = mem_rep[rd_ptr];
    assign out_tag   = mem_tag[rd_ptr];

    ////////////////////////////////////////////////////////////////////////////
    // pointers, occupancy, drops
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_retimer or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)  rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;             // both or neither
            endcase
        end
    end

    // saturating drop counter, clear wins
    always_ff @(posedge clk_retimer or negedge arst_n) begin
        if (!arst_n) begin
            drop_count <= '0;
        end else if (clear_drops) begin
            drop_count <= '0;
        end else if (push_valid && full && drop_count != '1) begin
            drop_count <= drop_count + 1'b1;
        end
    end

endmodule

// File: source/lane_retimer.sv
/* slice reorder and per-lane retiming: negative latch, mux 1, two flops, mux 2;
   replica slices through a single flop */
`timescale 1ns/10ps
`include "retimer_consts.svh"

module lane_retimer (
    input  logic                clk_retimer,
    input  logic                arst_n,
    // slice side, sampled on rising edge
    input  logic [`RT_NADC-1:0] in_data     [`RT_NTI],
    input  logic [`RT_NTI-1:0]  in_sign,
    input  logic [`RT_NADC-1:0] in_data_rep [`RT_NREP],
    input  logic [`RT_NREP-1:0] in_sign_rep,
    // per-lane path select
    input  logic [`RT_NTI-1:0]  mux_ctrl_1,
    input  logic [`RT_NTI-1:0]  mux_ctrl_2,
    // retimed lanes
    output logic [`RT_NADC-1:0] lane_data   [`RT_NTI],
    output logic [`RT_NTI-1:0]  lane_sign,
    output logic [`RT_NADC-1:0] rep_data    [`RT_NREP],
    output logic [`RT_NREP-1:0] rep_sign
);

    // sign rides in the msb so one path handles both
    logic [`RT_NADC:0] reorder [`RT_NTI];
    logic [`RT_NADC:0] neg_lat [`RT_NTI];
    logic [`RT_NADC:0] mux_1   [`RT_NTI];
    logic [`RT_NADC:0] flop_1  [`RT_NTI];
    logic [`RT_NADC:0] flop_2  [`RT_NTI];
    logic [`RT_NADC:0] mux_2   [`RT_NTI];

    ////////////////////////////////////////////////////////////////////////////
    // interleaved lanes
    ////////////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < `RT_NTI; k++) begin : g_lane
        // lane k takes slice (k mod 4)*4 + k div 4
        assign reorder[k] = {in_sign[(k % 4) * 4 + (k / 4)], in_data[(k % 4) * 4 + (k / 4)]};

        // transparent while clock low
        always_latch begin
            if (!clk_retimer) begin
                neg_lat[k] <= reorder[k];
            end
        end

        assign mux_1[k] = mux_ctrl_1[k] ? reorder[k] : neg_lat[k];   // bypass or latch

        always_ff @(posedge clk_retimer or negedge arst_n) begin
            if (!arst_n) begin
                flop_1[k] <= '0;
                flop_2[k] <= '0;
            end else begin
                flop_1[k] <= mux_1[k];
                flop_2[k] <= flop_1[k];              // one extra cycle
            end
        end

        assign mux_2[k] = mux_ctrl_2[k] ? flop_1[k] : flop_2[k];     // short or long

        assign lane_data[k] = mux_2[k][`RT_NADC-1:0];
        assign lane_sign[k] = mux_2[k][`RT_NADC];
    end

    ////////////////////////////////////////////////////////////////////////////
    // replicas, fixed one-flop path
    ////////////////////////////////////////////////////////////////////////////

    for (genvar r = 0; r < `RT_NREP; r++) begin : g_rep
        always_ff @(posedge clk_retimer or negedge arst_n) begin
            if (!arst_n) begin
                rep_data[r] <= '0;
                rep_sign[r] <= 1'b0;
            end else begin
                rep_data[r] <= in_data_rep[r];
                rep_sign[r] <= in_sign_rep[r];
            end
        end
    end

endmodule

// File: source/retimer_ctrl.sv
/* control block: config word decode, mux masks, settle counter,
   capture enable and the free-running sample index */
`timescale 1ns/10ps
`include "retimer_consts.svh"

module retimer_ctrl (
    input  logic                  clk_retimer,
    input  logic                  arst_n,
    // config port
    input  logic                  cfg_valid,
    output logic                  cfg_ready,
    input  logic                  cfg_is_mask,
    input  retimer_pkg::cfg_word_u cfg_word,
    // to lane retimer
    output logic [`RT_NTI-1:0]    mux_ctrl_1,
    output logic [`RT_NTI-1:0]    mux_ctrl_2,
    // to formatter and fifo
    output logic                  capture_on,
    output logic                  frame_valid,
    output logic [`RT_TAG_W-1:0]  frame_tag,
    output logic                  clear_drops
);

    localparam logic [1:0] SETTLE_CYCLES = 2'd3;   // frames held back after a mask load

    logic [1:0]           settle_cnt;
    logic                 cfg_fire;
    logic                 mask_fire;
    logic                 cmd_fire;
    logic [`RT_TAG_W-1:0] sample_idx;               // index of the next edge

    ////////////////////////////////////////////////////////////////////////////
    // handshake and decode
    ////////////////////////////////////////////////////////////////////////////

    assign cfg_ready = (settle_cnt == 2'd0);        // busy while settling
    assign cfg_fire  = cfg_valid & cfg_ready;
    assign mask_fire = cfg_fire & cfg_is_mask;      // masks view
    assign cmd_fire  = cfg_fire & ~cfg_is_mask;     // cmd view

    // masks come up as latch bypass + short path
    always_ff @(posedge clk_retimer or negedge arst_n) begin
        if (!arst_n) begin
            mux_ctrl_1 <= '1;
            mux_ctrl_2 <= '1;
        end else if (mask_fire) begin
            mux_ctrl_1 <= cfg_word.masks.mux_ctrl_1;
            mux_ctrl_2 <= cfg_word.masks.mux_ctrl_2;
        end
    end

    // settle window, lanes with a changed delay refill here
    always_ff @(posedge clk_retimer or negedge arst_n) begin
        if (!arst_n) begin
            settle_cnt <= 2'd0;
        end else if (mask_fire) begin
            settle_cnt <= SETTLE_CYCLES;
        end else if (settle_cnt != 2'd0) begin
            settle_cnt <= settle_cnt - 2'd1;
        end
    end

    // capture on/off; other opcodes leave it alone
    always_ff @(posedge clk_retimer or negedge arst_n) begin
        if (!arst_n) begin
            capture_on <= 1'b0;
        end else if (cmd_fire) begin
            case (cfg_word.cmd.opcode)
                `RT_OP_CAP_ON:  capture_on <= 1'b1;
                `RT_OP_CAP_OFF: capture_on <= 1'b0;
                default:        capture_on <= capture_on;
            endcase
        end
    end

    // one-cycle clear pulse to the fifo
    always_ff @(posedge clk_retimer or negedge arst_n) begin
        if (!arst_n) begin
            clear_drops <= 1'b0;
        end else begin
            clear_drops <= cmd_fire & cfg_word.cmd.clr_drops;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // sample index
    ////////////////////////////////////////////////////////////////////////////

    // first edge after reset release is index 0, wraps, ignores capture
    always_ff @(posedge clk_retimer or negedge arst_n) begin
        if (!arst_n) begin
            sample_idx <= '0;
            frame_tag  <= '0;
        end else begin
            sample_idx <= sample_idx + 1'b1;
            frame_tag  <= sample_idx;               // index of the edge just taken
        end
    end

    // no frames while settling
    assign frame_valid = capture_on & (settle_cnt == 2'd0);

endmodule

// File: source/retimer_pkg.sv
/* shared types: samples, frames, mask pair, command word and the
   configuration union that overlays them */
`include "retimer_consts.svh"

package retimer_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sample and frame types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic signed [`RT_SW-1:0] tc_sample_t;        // two's complement sample

    typedef tc_sample_t [`RT_NTI-1:0]  frame_t;           // one entry per lane
    typedef tc_sample_t [`RT_NREP-1:0] rep_frame_t;       // replica pair

    ////////////////////////////////////////////////////////////////////////////
    // configuration word, two views of the same 32 bits
    ////////////////////////////////////////////////////////////////////////////

    // mask view, mux_ctrl_1 in the low half
    typedef struct packed {
        logic [`RT_NTI-1:0] mux_ctrl_2;   // 1 = short path, flop 1
        logic [`RT_NTI-1:0] mux_ctrl_1;   // 1 = latch bypass
    } mux_masks_t;

    // command view
    typedef struct packed {
        logic [26:0] pad;                 // reserved, ignored
        logic        clr_drops;           // clear drop counter
        logic [3:0]  opcode;              // capture on / off, else no change
    } ctrl_cmd_t;

    // cfg_is_mask picks the view
    typedef union packed {
        mux_masks_t masks;
        ctrl_cmd_t  cmd;
    } cfg_word_u;

endpackage

// File: source/sample_formatter.sv
/* sign-magnitude to two's complement for all lanes and replicas,
   registered into one tagged frame */
`timescale 1ns/10ps
`include "retimer_consts.svh"

module sample_formatter (
    input  logic                    clk_retimer,
    input  logic                    arst_n,
    // retimed lanes
    input  logic [`RT_NADC-1:0]     lane_data [`RT_NTI],
    input  logic [`RT_NTI-1:0]      lane_sign,
    input  logic [`RT_NADC-1:0]     rep_data  [`RT_NREP],
    input  logic [`RT_NREP-1:0]     rep_sign,
    // from control
    input  logic                    frame_valid,
    input  logic [`RT_TAG_W-1:0]    frame_tag,
    // frame out, one cycle later
    output logic                    fmt_valid,
    output retimer_pkg::frame_t     fmt_frame,
    output retimer_pkg::rep_frame_t fmt_rep,
    output logic [`RT_TAG_W-1:0]    fmt_tag
);

    retimer_pkg::frame_t     tc_frame;
    retimer_pkg::rep_frame_t tc_rep;

    // sign high = negative; -0 negates to plain 0
    function automatic retimer_pkg::tc_sample_t to_tc(input logic [`RT_NADC-1:0] mag,
                                                     input logic sgn);
        retimer_pkg::tc_sample_t pos;
        pos = {1'b0, mag};                           // zero-extend magnitude
        return sgn ? -pos : pos;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // conversion
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < `RT_NTI; k++) begin
            tc_frame[k] = to_tc(lane_data[k], lane_sign[k]);
        end
        for (int r = 0; r < `RT_NREP; r++) begin
            tc_rep[r] = to_tc(rep_data[r], rep_sign[r]);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // frame register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_retimer or negedge arst_n) begin
        if (!arst_n) begin
            fmt_valid <= 1'b0;
        end else begin
            fmt_valid <= frame_valid;
        end
    end

    // payload, qualified by fmt_valid
    always_ff @(posedge clk_retimer) begin
        fmt_frame <= tc_frame;
        fmt_rep   <= tc_rep;
        fmt_tag   <= frame_tag;                      // short lanes hold this sample
    end

endmodule

// File: test/retimer_checker.sv
/* testbench checker: input history by sample index, mask, capture and
   settle model, frame and drop count comparison */
`timescale 1ns/10ps
`include "retimer_consts.svh"

module retimer_checker (
    input logic                    clk_retimer,
    input logic                    arst_n,
    input logic [`RT_NADC-1:0]     in_data     [`RT_NTI],
    input logic [`RT_NTI-1:0]      in_sign,
    input logic [`RT_NADC-1:0]     in_data_rep [`RT_NREP],
    input logic [`RT_NREP-1:0]     in_sign_rep,
    input logic                    cfg_valid,
    input logic                    cfg_ready,
    input logic                    cfg_is_mask,
    input retimer_pkg::cfg_word_u  cfg_word,
    input logic                    out_valid,
    input logic                    out_ready,
    input retimer_pkg::frame_t     out_frame,
    input retimer_pkg::rep_frame_t out_rep,
    input logic [`RT_TAG_W-1:0]    out_tag,
    input logic [15:0]             drop_count,
    input logic                    capture_on
);

    localparam int HIST = 1024;                       // edges kept, run is shorter

    logic [`RT_NADC:0]  slice_hist [HIST][`RT_NTI];   // {sign, mag} per edge
    logic [`RT_NADC:0]  rep_hist   [HIST][`RT_NREP];
    logic [`RT_NTI-1:0] short_hist [HIST];            // mux_ctrl_2 after each edge
    logic               valid_hist [HIST];            // frame expected for this tag
    logic [`RT_NTI-1:0] m_short;
    logic               m_cap;
    logic               take_cfg;
    int                 m_settle;
    int                 idx;
    int                 last_tag;
    int                 missing;                      // valid tags never seen
    int                 error_count = 0;
    int                 frames_checked = 0;
    int                 negzero_seen = 0;

    // sign set means negative
    function automatic logic [`RT_SW-1:0] sm_to_twos(input logic [`RT_NADC:0] raw);
        logic [`RT_SW-1:0] mag;
        mag = {1'b0, raw[`RT_NADC-1:0]};
        return raw[`RT_NADC] ? ~mag + 1'b1 : mag;
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic check_frame();
        int                t;
        int                src;
        logic [`RT_NADC:0] raw;
        t = out_tag;
        if (t >= HIST || !valid_hist[t]) begin
            report_error($sformatf("frame with tag %0d should not exist", t));
            return;
        end
        if (t <= last_tag) report_error($sformatf("tag %0d after tag %0d", t, last_tag));
        for (int g = last_tag + 1; g < t; g++) begin
            if (valid_hist[g]) missing++;             // dropped frame
        end
        for (int k = 0; k < `RT_NTI; k++) begin
            src = short_hist[t][k] ? t : t - 1;       // long lane lags one sample
            raw = slice_hist[(src < 0) ? 0 : src][(k % 4) * 4 + k / 4];
            if (raw == {1'b1, {`RT_NADC{1'b0}}}) negzero_seen++;
            if (out_frame[k] !== sm_to_twos(raw)) begin
                report_error($sformatf("tag %0d lane %0d got %h expected %h",
                                       t, k, out_frame[k], sm_to_twos(raw)));
            end
        end
        for (int r = 0; r < `RT_NREP; r++) begin
            if (out_rep[r] !== sm_to_twos(rep_hist[t][r])) begin
                report_error($sformatf("tag %0d replica %0d got %h expected %h",
                                       t, r, out_rep[r], sm_to_twos(rep_hist[t][r])));
            end
        end
        last_tag = t;
        frames_checked++;
    endtask

    always @(posedge clk_retimer or negedge arst_n) begin
        if (!arst_n) begin
            idx      = 0;
            m_short  = '1;
            m_cap    = 1'b0;
            m_settle = 0;
            last_tag = -1;
            missing  = 0;
        end else begin
            // pre-edge state against the model
            if (cfg_ready !== (m_settle == 0)) report_error("cfg_ready differs from model");
            if (capture_on !== m_cap) report_error("capture_on differs from model");
            if (out_valid && out_ready) check_frame();
            take_cfg = cfg_valid && (m_settle == 0);
            if (m_settle > 0) m_settle--;
            if (take_cfg && cfg_is_mask) begin
                m_short  = cfg_word.masks.mux_ctrl_2;
                m_settle = 3;
            end else if (take_cfg) begin
                if (cfg_word.cmd.opcode == `RT_OP_CAP_ON) m_cap = 1'b1;
                if (cfg_word.cmd.opcode == `RT_OP_CAP_OFF) m_cap = 1'b0;
                if (cfg_word.cmd.clr_drops && drop_count != 16'(missing)) begin
                    report_error($sformatf("drop_count %0d, missing frames %0d",
                                           drop_count, missing));
                end
                if (cfg_word.cmd.clr_drops) missing = 0;
            end
            if (idx < HIST) begin                     // state after this edge
                for (int s = 0; s < `RT_NTI; s++) slice_hist[idx][s] = {in_sign[s], in_data[s]};
                for (int r = 0; r < `RT_NREP; r++) begin
                    rep_hist[idx][r] = {in_sign_rep[r], in_data_rep[r]};
                end
                short_hist[idx] = m_short;
                valid_hist[idx] = m_cap && (m_settle == 0);
            end
            idx++;
        end
    end

endmodule

// File: test/tb_adc_retimer.sv
/* testbench top: clock, reset, lcg stimulus, configuration sequence,
   output back-pressure, watchdog and closing result */
`timescale 1ns/10ps
`include "retimer_consts.svh"

module tb_adc_retimer;

    localparam int PHASE_CYCLES = 40;
    localparam int BP_CYCLES    = 160;
    localparam int STIM_CYCLES  = 8 + 3 * PHASE_CYCLES + BP_CYCLES + 80;

    logic                    clk_retimer = 1'b0;
    logic                    arst_n;
    logic [`RT_NADC-1:0]     in_data     [`RT_NTI];
    logic [`RT_NTI-1:0]      in_sign;
    logic [`RT_NADC-1:0]     in_data_rep [`RT_NREP];
    logic [`RT_NREP-1:0]     in_sign_rep;
    logic                    cfg_valid;
    logic                    cfg_ready;
    logic                    cfg_is_mask;
    retimer_pkg::cfg_word_u  cfg_word;
    logic                    out_valid;
    logic                    out_ready;
    retimer_pkg::frame_t     out_frame;
    retimer_pkg::rep_frame_t out_rep;
    logic [`RT_TAG_W-1:0]    out_tag;
    logic [15:0]             drop_count;
    logic                    capture_on;

    logic [31:0]        lcg_state = 32'd41;
    logic               random_ready;                 // back-pressure phase
    logic [`RT_NTI-1:0] short_mask;
    logic [`RT_NTI-1:0] latch_mask;                   // mux_ctrl_1 for the latch phase
    int                 tb_errors = 0;

    adc_retimer_top dut_i (.*);
    retimer_checker chk_i (.*);

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];                      // upper bits, better period
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // clock, watchdog, falling-edge stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        forever #50 clk_retimer = ~clk_retimer;
    end

    initial begin
        #((STIM_CYCLES + 200) * 100);
        $display("Timeout: the run did not end within %0d cycles", STIM_CYCLES + 200);
        $display("Checks failed");
        $finish;
    end

    always @(negedge clk_retimer) begin
        logic [15:0] r;
        for (int s = 0; s < `RT_NTI; s++) begin
            r          = lcg_next();
            in_data[s] = (r[11:9] == 3'd0) ? '0 : r[7:0];   // zero mag now and then
            in_sign[s] = r[12];
        end
        for (int p = 0; p < `RT_NREP; p++) begin
            r              = lcg_next();
            in_data_rep[p] = r[7:0];
            in_sign_rep[p] = r[12];
        end
        r         = lcg_next();
        out_ready = random_ready ? r[3] : 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // config helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_retimer);
    endtask

    // hold the word until the edge with ready high
    task automatic send_cfg(input logic is_mask, input retimer_pkg::cfg_word_u word);
        @(negedge clk_retimer);
        cfg_valid   = 1'b1;
        cfg_is_mask = is_mask;
        cfg_word    = word;
        while (!cfg_ready) @(negedge clk_retimer);
        @(negedge clk_retimer);
        cfg_valid = 1'b0;
    endtask

    task automatic send_cmd(input logic [3:0] op, input logic clr);
        retimer_pkg::cfg_word_u w;
        w               = '0;
        w.cmd.opcode    = op;
        w.cmd.clr_drops = clr;
        send_cfg(1'b0, w);
    endtask

    task automatic send_masks(input logic [15:0] m1, input logic [15:0] m2);
        retimer_pkg::cfg_word_u w;
        w.masks.mux_ctrl_1 = m1;
        w.masks.mux_ctrl_2 = m2;
        send_cfg(1'b1, w);
    endtask

    task automatic expect_zero(input logic [15:0] value, input string what);
        if (value !== '0) begin
            tb_errors++;
            $display("Error at %0t ns: %s is %0d, expected 0", $time, what, value);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        arst_n       = 1'b0;
        cfg_valid    = 1'b0;
        cfg_is_mask  = 1'b0;
        cfg_word     = '0;
        out_ready    = 1'b1;
        random_ready = 1'b0;
        in_data      = '{default: '0};
        in_sign      = '0;
        in_data_rep  = '{default: '0};
        in_sign_rep  = '0;
        short_mask   = lcg_next();                    // drawn before the first edge
        latch_mask   = lcg_next();
        wait_cycles(8);
        arst_n = 1'b1;

        send_cmd(`RT_OP_CAP_ON, 1'b0);                // default masks
        wait_cycles(PHASE_CYCLES);
        send_masks('1, short_mask);                   // mixed delays
        wait_cycles(PHASE_CYCLES);
        send_masks(latch_mask, short_mask);           // latch path on some lanes
        wait_cycles(PHASE_CYCLES);
        random_ready = 1'b1;
        wait_cycles(BP_CYCLES);
        random_ready = 1'b0;
        wait_cycles(20);

        if (drop_count == '0) begin
            tb_errors++;
            $display("No frame was dropped under back-pressure");
        end
        send_cmd(4'h0, 1'b1);                         // clear drops only
        wait_cycles(2);
        expect_zero(drop_count, "drop_count after clear");
        send_cmd(`RT_OP_CAP_OFF, 1'b0);
        wait_cycles(10);                              // fifo drains
        repeat (20) begin
            @(negedge clk_retimer);
            expect_zero(16'(out_valid), "out_valid after capture off");
        end
        expect_zero(16'(capture_on), "capture_on");

        if (chk_i.frames_checked < 150) begin
            tb_errors++;
            $display("Too few frames reached the output: %0d", chk_i.frames_checked);
        end
        if (chk_i.negzero_seen == 0) begin
            tb_errors++;
            $display("No negative-zero sample reached the output");
        end
        $display("Error counts: checker %0d, testbench %0d", chk_i.error_count, tb_errors);
        if (chk_i.error_count == 0 && tb_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
